//--- src/msi_pkg.sv
/*
 * msi controller shared definitions
 * sizes, message / table / control structs and the register word map
 */
package msi_pkg;

	// ========================================================================
	// sizes
	// ========================================================================
	localparam int NPRI   = 8;		// priority levels, one queue each
	localparam int NVEC   = 64;		// interrupt vectors
	localparam int VEC_W  = 6;
	localparam int PRI_W  = 3;
	localparam int QDEPTH = 4;		// default queue depth
	localparam int DAT_W  = 32;		// register data
	localparam int ADR_W  = 7;		// register word address
	localparam int HND_W  = 16;		// handler address

	// message as posted by a device
	typedef struct packed {
		logic [VEC_W-1:0] vecno;
		logic [PRI_W-1:0] pri;
		logic [7:0]       data;
	} msi_msg_t;

	// vector table entry, ie lands on bit 16 of a register word
	typedef struct packed {
		logic             ie;
		logic [HND_W-1:0] handler;
	} msi_vec_t;

	typedef struct packed {
		logic             global_en;
		logic [PRI_W-1:0] threshold;	// deliver only pri above this
	} msi_cfg_t;

	// interrupt as presented to the cpu
	typedef struct packed {
		logic [VEC_W-1:0] vecno;
		logic [PRI_W-1:0] pri;
		logic [7:0]       data;
		logic [HND_W-1:0] handler;
	} msi_irq_t;

	// ========================================================================
	// register word addresses
	// ========================================================================
	localparam logic [ADR_W-1:0] REG_CTRL    = 7'h00;	// {threshold, global_en}
	localparam logic [ADR_W-1:0] REG_STAT    = 7'h01;	// queue non-empty mask
	localparam logic [ADR_W-1:0] REG_EN_LO   = 7'h02;
	localparam logic [ADR_W-1:0] REG_EN_HI   = 7'h03;
	localparam logic [ADR_W-1:0] REG_PEND_LO = 7'h04;	// write one to clear
	localparam logic [ADR_W-1:0] REG_PEND_HI = 7'h05;
	localparam logic [ADR_W-1:0] REG_VT_BASE = 7'h40;	// 64 table words

endpackage

//--- src/msi_vec_table.sv
/*
 * vector table
 * dual-port memory of enable bit and handler per vector, port a for the
 * register side (read/write), port b for the dispatch lookup
 */
module msi_vec_table (
	input  logic                      clk,
	input  logic                      a_we_i,
	input  logic [msi_pkg::VEC_W-1:0] a_addr_i,
	input  msi_pkg::msi_vec_t         a_din_i,
	output msi_pkg::msi_vec_t         a_dout_o,
	input  logic [msi_pkg::VEC_W-1:0] b_addr_i,
	output msi_pkg::msi_vec_t         b_dout_o
);

	msi_pkg::msi_vec_t mem [msi_pkg::NVEC];	// contents undefined until written

	// port a, read returns the old word on a write cycle
	always_ff @(posedge clk) begin
		if (a_we_i)
			mem[a_addr_i] <= a_din_i;
		a_dout_o <= mem[a_addr_i];
	end

	// port b, read only
	always_ff @(posedge clk)
		b_dout_o <= mem[b_addr_i];

endmodule

//--- src/msi_queue.sv
/*
 * message queue
 * small synchronous fifo for one priority level, head readable directly
 */
module msi_queue #(
	parameter int DEPTH = msi_pkg::QDEPTH
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              push_i,
	input  msi_pkg::msi_msg_t din_i,
	input  logic              pop_i,
	output logic              full_o,
	output logic              nempty_o,
	output msi_pkg::msi_msg_t head_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	msi_pkg::msi_msg_t mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;		// entries held

	// pointer step with wrap, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop_i)
				rd_ptr <= ptr_next(rd_ptr);
			if (push_i && !pop_i)
				count <= count + 1'b1;
			else if (pop_i && !push_i)
				count <= count - 1'b1;	// push and pop together keep the count
		end
	end

	always_ff @(posedge clk)
		if (push_i)
			mem[wr_ptr] <= din_i;

	assign head_o   = mem[rd_ptr];		// no read latency
	assign full_o   = (count == CNT_W'(DEPTH));
	assign nempty_o = (count != '0);

	// dispatcher only pops a queue it saw non-empty
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		pop_i |-> nempty_o);

endmodule

//--- src/msi_intake.sv
/*
 * message intake
 * four-phase receiver, steers each message to the queue of its priority,
 * waits for room and flags the vector for the pending bit
 */
module msi_intake #(
	parameter int NPRI = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              msg_req_i,
	input  msi_pkg::msi_msg_t msg_i,
	output logic              msg_ack_o,
	input  logic [NPRI-1:0]   q_full_i,
	output logic [NPRI-1:0]   push_o,
	output msi_pkg::msi_msg_t push_msg_o,
	output logic              pend_set_o,
	output logic [msi_pkg::VEC_W-1:0] pend_vec_o
);

	typedef enum logic [1:0] {S_IDLE, S_WAIT, S_PUSH, S_ACK} state_t;

	state_t            state;
	msi_pkg::msi_msg_t msg_r;		// message held for the push

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= S_IDLE;
			msg_ack_o <= 1'b0;
		end else begin
			case (state)
			S_IDLE:
				if (msg_req_i)
					state <= S_WAIT;
			S_WAIT:
				if (!q_full_i[msg_r.pri])	// back-pressure, hold here
					state <= S_PUSH;
			S_PUSH: begin
				msg_ack_o <= 1'b1;		// queue written on this edge
				state     <= S_ACK;
			end
			default:
				if (!msg_req_i) begin
					msg_ack_o <= 1'b0;
					state     <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
		if (state == S_IDLE && msg_req_i)
			msg_r <= msg_i;

	// single push strobe to the selected queue
	assign push_o     = (state == S_PUSH) ? ({{(NPRI-1){1'b0}}, 1'b1} << msg_r.pri) : '0;
	assign push_msg_o = msg_r;
	assign pend_set_o = (state == S_PUSH);
	assign pend_vec_o = msg_r.vecno;

	// room was checked one cycle earlier, only pops can happen in between
	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		(push_o & q_full_i) == '0);

endmodule

//--- src/msi_dispatch.sv
/*
 * dispatcher
 * picks the highest non-empty priority queue, pops it, looks the vector up,
 * filters on the enables and threshold and runs the cpu handshake
 */
module msi_dispatch #(
	parameter int NPRI = 8
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [NPRI-1:0]                   nempty_i,
	input  msi_pkg::msi_msg_t [NPRI-1:0]      heads_i,
	output logic [NPRI-1:0]                   pop_o,
	input  msi_pkg::msi_cfg_t                 cfg_i,
	input  logic [msi_pkg::NVEC-1:0]          en_i,
	output logic [msi_pkg::VEC_W-1:0]         vt_addr_o,
	input  msi_pkg::msi_vec_t                 vt_entry_i,
	output logic                              irq_o,
	output msi_pkg::msi_irq_t                 irq_info_o,
	input  logic                              irq_ack_i
);

	localparam int SEL_W = (NPRI > 1) ? $clog2(NPRI) : 1;

	typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_PRESENT, S_RELEASE} state_t;

	state_t            state;
	logic [SEL_W-1:0]  sel;			// highest non-empty queue
	msi_pkg::msi_msg_t msg_r;		// popped message
	logic              deliver;

	// ========================================================================
	// queue selection
	// ========================================================================
	always_comb begin
		sel = '0;
		for (int i = 0; i < NPRI; i++)
			if (nempty_i[i])
				sel = SEL_W'(i);	// later index overrides, top priority wins
	end

	assign pop_o     = (state == S_IDLE && |nempty_i) ? ({{(NPRI-1){1'b0}}, 1'b1} << sel) : '0;
	assign vt_addr_o = (state == S_IDLE) ? heads_i[sel].vecno : msg_r.vecno;

	// all four conditions must hold, entry arrives the cycle after the pop
	assign deliver = cfg_i.global_en && en_i[msg_r.vecno] && vt_entry_i.ie
		&& (msg_r.pri > cfg_i.threshold);

	// ========================================================================
	// state machine
	// ========================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			irq_o <= 1'b0;
		end else begin
			case (state)
			S_IDLE:
				if (|nempty_i)
					state <= S_LOOKUP;
			S_LOOKUP:
				if (deliver) begin
					irq_o <= 1'b1;
					state <= S_PRESENT;
				end else begin
					state <= S_IDLE;	// filtered out, message dropped
				end
			S_PRESENT:
				if (irq_ack_i) begin
					irq_o <= 1'b0;
					state <= S_RELEASE;
				end
			default:
				if (!irq_ack_i)		// cpu must drop ack before the next one
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE)
			msg_r <= heads_i[sel];
		if (state == S_LOOKUP && deliver) begin
			irq_info_o.vecno   <= msg_r.vecno;
			irq_info_o.pri     <= msg_r.pri;
			irq_info_o.data    <= msg_r.data;
			irq_info_o.handler <= vt_entry_i.handler;
		end
	end

	a_info_stable: assert property (@(posedge clk) disable iff (rst)
		irq_o |=> !irq_o || $stable(irq_info_o));

endmodule

//--- src/msi_regs.sv
/*
 * register port
 * four-phase host access to control, vector enables, pending bits,
 * queue status and the vector table
 */
module msi_regs #(
	parameter int NPRI = 8
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      reg_req_i,
	input  logic                      reg_we_i,
	input  logic [msi_pkg::ADR_W-1:0] reg_adr_i,
	input  logic [msi_pkg::DAT_W-1:0] reg_wdat_i,
	output logic                      reg_ack_o,
	output logic [msi_pkg::DAT_W-1:0] reg_rdat_o,
	input  logic                      pend_set_i,
	input  logic [msi_pkg::VEC_W-1:0] pend_vec_i,
	input  logic [NPRI-1:0]           nempty_i,
	output msi_pkg::msi_cfg_t         cfg_o,
	output logic [msi_pkg::NVEC-1:0]  en_o,
	output logic                      vt_we_o,
	output logic [msi_pkg::VEC_W-1:0] vt_addr_o,
	output msi_pkg::msi_vec_t         vt_din_o,
	input  msi_pkg::msi_vec_t         vt_dout_i
);

	localparam int DW = msi_pkg::DAT_W;
	localparam int VW = msi_pkg::VEC_W;

	typedef enum logic [1:0] {S_IDLE, S_ACCESS, S_READ, S_ACK} state_t;

	state_t                   state;
	logic [msi_pkg::ADR_W-1:0] adr_r;	// captured request
	logic                      we_r;
	logic [DW-1:0]             wdat_r;
	logic [msi_pkg::NVEC-1:0]  pend;
	logic [msi_pkg::NVEC-1:0]  pend_clr;
	logic                      wr;		// write strobe, one cycle
	logic                      is_vt;	// vector table window
	logic [DW-1:0]             rdat;

	assign wr    = (state == S_ACCESS) && we_r;
	assign is_vt = (adr_r[msi_pkg::ADR_W-1:VW] == msi_pkg::REG_VT_BASE[msi_pkg::ADR_W-1:VW]);

	// ========================================================================
	// handshake, ack two cycles after req, drop one after req falls
	// ========================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= S_IDLE;
			reg_ack_o <= 1'b0;
		end else begin
			case (state)
			S_IDLE:   if (reg_req_i) state <= S_ACCESS;
			S_ACCESS: state <= S_READ;	// write and table read happen here
			S_READ: begin
				reg_ack_o <= 1'b1;
				state     <= S_ACK;
			end
			default:
				if (!reg_req_i) begin
					reg_ack_o <= 1'b0;
					state     <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && reg_req_i) begin
			adr_r  <= reg_adr_i;
			we_r   <= reg_we_i;
			wdat_r <= reg_wdat_i;
		end
		if (state == S_READ)
			reg_rdat_o <= rdat;	// held while ack is high
	end

	// ========================================================================
	// control, enable and pending state
	// ========================================================================
	always_comb begin
		pend_clr = '0;
		if (wr && adr_r == msi_pkg::REG_PEND_LO)
			pend_clr[DW-1:0] = wdat_r;
		if (wr && adr_r == msi_pkg::REG_PEND_HI)
			pend_clr[2*DW-1:DW] = wdat_r;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg_o <= '0;
			en_o  <= '0;
			pend  <= '0;
		end else begin
			if (wr && adr_r == msi_pkg::REG_CTRL) begin
				cfg_o.global_en <= wdat_r[0];
				cfg_o.threshold <= wdat_r[3:1];
			end
			if (wr && adr_r == msi_pkg::REG_EN_LO)
				en_o[DW-1:0] <= wdat_r;
			if (wr && adr_r == msi_pkg::REG_EN_HI)
				en_o[2*DW-1:DW] <= wdat_r;
			// set applied after clear so a new message is never lost
			pend <= (pend & ~pend_clr) | ({{(msi_pkg::NVEC-1){1'b0}}, pend_set_i} << pend_vec_i);
		end
	end

	// table port a, word index is the low address bits
	assign vt_we_o   = wr && is_vt;
	assign vt_addr_o = adr_r[VW-1:0];
	assign vt_din_o  = wdat_r[$bits(msi_pkg::msi_vec_t)-1:0];

	// read mux
	always_comb begin
		rdat = '0;
		if (is_vt)
			rdat = DW'(vt_dout_i);		// ie at bit 16
		else
			case (adr_r)
			msi_pkg::REG_CTRL:    rdat = DW'({cfg_o.threshold, cfg_o.global_en});
			msi_pkg::REG_STAT:    rdat = DW'(nempty_i);
			msi_pkg::REG_EN_LO:   rdat = en_o[DW-1:0];
			msi_pkg::REG_EN_HI:   rdat = en_o[2*DW-1:DW];
			msi_pkg::REG_PEND_LO: rdat = pend[DW-1:0];
			msi_pkg::REG_PEND_HI: rdat = pend[2*DW-1:DW];
			default:              rdat = '0;
			endcase
	end

endmodule

//--- src/msi_ctrl.sv
/*
 * msi interrupt controller, top level
 * intake, per-priority queues, dispatcher, vector table and register port
 */
module msi_ctrl #(
	parameter int NPRI   = msi_pkg::NPRI,
	parameter int QDEPTH = msi_pkg::QDEPTH
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      msg_req_i,
	input  msi_pkg::msi_msg_t         msg_i,
	output logic                      msg_ack_o,
	input  logic                      reg_req_i,
	input  logic                      reg_we_i,
	input  logic [msi_pkg::ADR_W-1:0] reg_adr_i,
	input  logic [msi_pkg::DAT_W-1:0] reg_wdat_i,
	output logic                      reg_ack_o,
	output logic [msi_pkg::DAT_W-1:0] reg_rdat_o,
	output logic                      irq_o,
	output msi_pkg::msi_irq_t         irq_info_o,
	input  logic                      irq_ack_i
);

	// intake to queues and pending
	logic [NPRI-1:0]              push;
	msi_pkg::msi_msg_t            push_msg;
	logic                         pend_set;
	logic [msi_pkg::VEC_W-1:0]    pend_vec;
	// queues to dispatch
	logic [NPRI-1:0]              q_full;
	logic [NPRI-1:0]              nempty;
	logic [NPRI-1:0]              pop;
	msi_pkg::msi_msg_t [NPRI-1:0] heads;
	// registers to dispatch and table
	msi_pkg::msi_cfg_t            cfg;
	logic [msi_pkg::NVEC-1:0]     en;
	logic                         vt_we;
	logic [msi_pkg::VEC_W-1:0]    vt_addr_a;
	logic [msi_pkg::VEC_W-1:0]    vt_addr_b;
	msi_pkg::msi_vec_t            vt_din;
	msi_pkg::msi_vec_t            vt_dout_a;
	msi_pkg::msi_vec_t            vt_entry;

	msi_intake #(.NPRI(NPRI)) i_intake (
		.clk, .rst,
		.msg_req_i, .msg_i, .msg_ack_o,
		.q_full_i   (q_full),
		.push_o     (push),
		.push_msg_o (push_msg),
		.pend_set_o (pend_set),
		.pend_vec_o (pend_vec)
	);

	// one queue per priority level, index = priority
	for (genvar g = 0; g < NPRI; g++) begin : g_queue
		msi_queue #(.DEPTH(QDEPTH)) i_queue (
			.clk, .rst,
			.push_i   (push[g]),
			.din_i    (push_msg),
			.pop_i    (pop[g]),
			.full_o   (q_full[g]),
			.nempty_o (nempty[g]),
			.head_o   (heads[g])
		);
	end

	msi_dispatch #(.NPRI(NPRI)) i_dispatch (
		.clk, .rst,
		.nempty_i   (nempty),
		.heads_i    (heads),
		.pop_o      (pop),
		.cfg_i      (cfg),
		.en_i       (en),
		.vt_addr_o  (vt_addr_b),
		.vt_entry_i (vt_entry),
		.irq_o, .irq_info_o, .irq_ack_i
	);

	msi_vec_table i_vec_table (
		.clk,
		.a_we_i   (vt_we),
		.a_addr_i (vt_addr_a),
		.a_din_i  (vt_din),
		.a_dout_o (vt_dout_a),
		.b_addr_i (vt_addr_b),
		.b_dout_o (vt_entry)
	);

	msi_regs #(.NPRI(NPRI)) i_regs (
		.clk, .rst,
		.reg_req_i, .reg_we_i, .reg_adr_i, .reg_wdat_i, .reg_ack_o, .reg_rdat_o,
		.pend_set_i (pend_set),
		.pend_vec_i (pend_vec),
		.nempty_i   (nempty),
		.cfg_o      (cfg),
		.en_o       (en),
		.vt_we_o    (vt_we),
		.vt_addr_o  (vt_addr_a),
		.vt_din_o   (vt_din),
		.vt_dout_i  (vt_dout_a)
	);

endmodule

//--- testbench/tb_msi_ref.svh
/*
 * msi controller reference model
 * software-visible state and the delivery rule, predicts register
 * read data and the interrupts the cpu should see
 */
`ifndef TB_MSI_REF_SVH
`define TB_MSI_REF_SVH

logic [msi_pkg::NVEC-1:0]  m_en;		// per-vector enable
logic [msi_pkg::NVEC-1:0]  m_pend;		// pending, set by every accepted message
logic                      m_gen;		// global enable
logic [msi_pkg::PRI_W-1:0] m_thr;
logic                      m_ie  [msi_pkg::NVEC];
logic [msi_pkg::HND_W-1:0] m_hnd [msi_pkg::NVEC];

function automatic void model_reset();
	m_en   = '0;
	m_pend = '0;
	m_gen  = 1'b0;
	m_thr  = '0;
endfunction

// effect of one register write
function automatic void model_write(input logic [6:0] adr, input logic [31:0] d);
	if (adr >= msi_pkg::REG_VT_BASE) begin
		m_ie[adr[5:0]]  = d[16];
		m_hnd[adr[5:0]] = d[15:0];
	end else begin
		case (adr)
		msi_pkg::REG_CTRL: begin
			m_gen = d[0];
			m_thr = d[3:1];
		end
		msi_pkg::REG_EN_LO:   m_en[31:0]    = d;
		msi_pkg::REG_EN_HI:   m_en[63:32]   = d;
		msi_pkg::REG_PEND_LO: m_pend[31:0]  = m_pend[31:0] & ~d;	// ones clear
		msi_pkg::REG_PEND_HI: m_pend[63:32] = m_pend[63:32] & ~d;
		default: ;
		endcase
	end
endfunction

// status only read while the queues are empty, so it stays zero
function automatic logic [31:0] model_read(input logic [6:0] adr);
	logic [31:0] d;
	d = '0;
	if (adr >= msi_pkg::REG_VT_BASE)
		d = {15'b0, m_ie[adr[5:0]], m_hnd[adr[5:0]]};
	else
		case (adr)
		msi_pkg::REG_CTRL:    d = {28'b0, m_thr, m_gen};
		msi_pkg::REG_EN_LO:   d = m_en[31:0];
		msi_pkg::REG_EN_HI:   d = m_en[63:32];
		msi_pkg::REG_PEND_LO: d = m_pend[31:0];
		msi_pkg::REG_PEND_HI: d = m_pend[63:32];
		default:              d = '0;
		endcase
	return d;
endfunction

// delivered only when all enables hold and the priority clears the threshold
function automatic logic predict_irq(input msi_pkg::msi_msg_t m,
		output msi_pkg::msi_irq_t irq);
	irq.vecno   = m.vecno;
	irq.pri     = m.pri;
	irq.data    = m.data;
	irq.handler = m_hnd[m.vecno];
	return m_gen && m_en[m.vecno] && m_ie[m.vecno] && (m.pri > m_thr);
endfunction

`endif

//--- testbench/tb_msi_ctrl.sv
/*
 * testbench for the msi interrupt controller
 * register, pending, filter, priority order and back-pressure checks
 * against a reference model, cpu side answered by a responder process
 */
module tb_msi_ctrl;

	localparam int          QD    = msi_pkg::QDEPTH;
	localparam int unsigned LIMIT = 200 * 50 + 20000;	// 200 messages plus register phases

	logic                      clk;
	logic                      rst;
	logic                      msg_req_i;
	msi_pkg::msi_msg_t         msg_i;
	logic                      msg_ack_o;
	logic                      reg_req_i;
	logic                      reg_we_i;
	logic [msi_pkg::ADR_W-1:0] reg_adr_i;
	logic [msi_pkg::DAT_W-1:0] reg_wdat_i;
	logic                      reg_ack_o;
	logic [msi_pkg::DAT_W-1:0] reg_rdat_o;
	logic                      irq_o;
	msi_pkg::msi_irq_t         irq_info_o;
	logic                      irq_ack_i;

	logic [31:0]       lfsr = 32'h20d2efd2;
	logic              cpu_hold;		// responder withholds ack while set
	msi_pkg::msi_irq_t exp_q [$];		// predicted deliveries in order
	msi_pkg::msi_irq_t got_q [$];		// interrupts taken by the cpu
	int unsigned       cycles = 0;

	`include "tb_msi_ref.svh"

	msi_ctrl #(.NPRI(msi_pkg::NPRI), .QDEPTH(QD)) i_dut (
		.clk, .rst,
		.msg_req_i, .msg_i, .msg_ack_o,
		.reg_req_i, .reg_we_i, .reg_adr_i, .reg_wdat_i, .reg_ack_o, .reg_rdat_o,
		.irq_o, .irq_info_o, .irq_ack_i
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout, the run did not finish within %0d cycles", LIMIT);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	// =========================================================================
	// helpers
	// =========================================================================
	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic msi_pkg::msi_msg_t rand_msg(input logic [2:0] pri);
		msi_pkg::msi_msg_t m;
		m.vecno = 6'(rand_bits(6));
		m.pri   = pri;
		m.data  = 8'(rand_bits(8));
		return m;
	endfunction

	task automatic check_eq(input string name, input logic [63:0] got_v,
			input logic [63:0] exp_v);
		if (got_v !== exp_v) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got_v, exp_v);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic void expect_msg(input msi_pkg::msi_msg_t m);
		msi_pkg::msi_irq_t irq;
		if (predict_irq(m, irq))
			exp_q.push_back(irq);
	endfunction

	// four-phase register access
	task automatic reg_access(input logic we, input logic [6:0] adr,
			input logic [31:0] wdat, output logic [31:0] rdat);
		@(negedge clk);
		reg_req_i  = 1'b1;
		reg_we_i   = we;
		reg_adr_i  = adr;
		reg_wdat_i = wdat;
		do @(negedge clk); while (!reg_ack_o);
		rdat      = reg_rdat_o;		// valid while ack high
		reg_req_i = 1'b0;
		do @(negedge clk); while (reg_ack_o);
	endtask

	task automatic reg_write(input logic [6:0] adr, input logic [31:0] d);
		logic [31:0] unused;
		reg_access(1'b1, adr, d, unused);
		model_write(adr, d);
	endtask

	task automatic reg_check(input logic [6:0] adr);
		logic [31:0] r;
		reg_access(1'b0, adr, 32'h0, r);
		check_eq("reg_rdat_o", 64'(r), 64'(model_read(adr)));
	endtask

	task automatic msg_begin(input msi_pkg::msi_msg_t m);
		@(negedge clk);
		msg_req_i = 1'b1;
		msg_i     = m;
	endtask

	task automatic msg_end();
		do @(negedge clk); while (!msg_ack_o);
		msg_req_i = 1'b0;
		do @(negedge clk); while (msg_ack_o);
	endtask

	task automatic send_msg(input msi_pkg::msi_msg_t m);
		msg_begin(m);
		msg_end();
		m_pend[m.vecno] = 1'b1;		// accepted message sets its pending bit
	endtask

	task automatic wait_irq();
		do @(negedge clk); while (!irq_o);
	endtask

	// all predictions consumed and queues empty
	task automatic wait_drain();
		logic [31:0] stat;
		do @(negedge clk); while (exp_q.size() != 0 || got_q.size() != 0 || irq_o);
		do reg_access(1'b0, msi_pkg::REG_STAT, 32'h0, stat); while (stat != 32'h0);
	endtask

	// =========================================================================
	// cpu responder and compare
	// =========================================================================
	initial begin : cpu_responder
		int dly;
		irq_ack_i = 1'b0;
		forever begin
			@(negedge clk);
			if (irq_o) begin
				got_q.push_back(irq_info_o);
				while (cpu_hold)
					@(negedge clk);
				dly = int'(rand_bits(2));
				repeat (dly) @(negedge clk);
				irq_ack_i = 1'b1;
				do @(negedge clk); while (irq_o);
				irq_ack_i = 1'b0;
			end
		end
	end

	initial begin : compare
		msi_pkg::msi_irq_t g;
		msi_pkg::msi_irq_t e;
		forever begin
			@(posedge clk);
			while (got_q.size() != 0) begin
				g = got_q.pop_front();
				if (exp_q.size() == 0) begin
					$display("interrupt for vector %0d was raised but none was expected",
						g.vecno);
					$display("TEST RESULT: FAIL");
					$fatal(1, "unexpected interrupt");
				end else begin
					e = exp_q.pop_front();
					check_eq("irq_info_o.vecno", 64'(g.vecno), 64'(e.vecno));
					check_eq("irq_info_o.pri", 64'(g.pri), 64'(e.pri));
					check_eq("irq_info_o.data", 64'(g.data), 64'(e.data));
					check_eq("irq_info_o.handler", 64'(g.handler), 64'(e.handler));
				end
			end
		end
	end

	// =========================================================================
	// ordered delivery rounds
	// =========================================================================
	// first message held at the cpu while a mixed batch queues behind it
	task automatic priority_round();
		msi_pkg::msi_msg_t m;
		msi_pkg::msi_msg_t batch [$];
		logic [2:0]        p;
		int                cnt [8];
		foreach (cnt[i])
			cnt[i] = 0;
		cpu_hold = 1'b1;
		m = rand_msg(3'd1 | 3'(rand_bits(3)));
		expect_msg(m);
		send_msg(m);
		wait_irq();
		for (int i = 0; i < 10; i++) begin
			p = 3'(rand_bits(3));
			while (p == 3'd0 || cnt[p] == QD)	// pri 0 never clears threshold 0
				p = p + 3'd1;
			cnt[p]++;
			m = rand_msg(p);
			batch.push_back(m);
			send_msg(m);
		end
		// highest level first and arrival order within a level
		for (int q = 7; q >= 0; q--)
			foreach (batch[j])
				if (batch[j].pri == 3'(q))
					expect_msg(batch[j]);
		cpu_hold = 1'b0;
		wait_drain();
	endtask

	// one level overfilled while the cpu holds ack
	task automatic backpressure_round();
		msi_pkg::msi_msg_t m;
		logic [2:0]        p;
		logic [31:0]       stat;
		p = 3'd1 | 3'(rand_bits(3));
		cpu_hold = 1'b1;
		for (int i = 0; i < QD + 1; i++) begin
			m = rand_msg(p);
			expect_msg(m);
			send_msg(m);
			if (i == 0)
				wait_irq();		// first one leaves the queue
		end
		m = rand_msg(p);
		expect_msg(m);
		msg_begin(m);
		repeat (20) begin
			@(negedge clk);
			check_eq("msg_ack_o", 64'(msg_ack_o), 64'd0);
		end
		// only the overfilled level holds messages
		reg_access(1'b0, msi_pkg::REG_STAT, 32'h0, stat);
		check_eq("reg_rdat_o", 64'(stat), 64'd1 << p);
		cpu_hold = 1'b0;
		msg_end();
		m_pend[m.vecno] = 1'b1;
		wait_drain();
	endtask

	// =========================================================================
	// main sequence
	// =========================================================================
	initial begin : main
		msi_pkg::msi_msg_t m;
		logic [2:0]        thr;
		msg_req_i  = 1'b0;
		msg_i      = '0;
		reg_req_i  = 1'b0;
		reg_we_i   = 1'b0;
		reg_adr_i  = '0;
		reg_wdat_i = '0;
		cpu_hold   = 1'b0;
		model_reset();
		rst = 1'b1;
		repeat (4) @(negedge clk);
		rst = 1'b0;

		// register read-back
		reg_write(msi_pkg::REG_CTRL, rand_bits(4));
		reg_check(msi_pkg::REG_CTRL);
		reg_write(msi_pkg::REG_EN_LO, rand_bits(32));
		reg_write(msi_pkg::REG_EN_HI, rand_bits(32));
		reg_check(msi_pkg::REG_EN_LO);
		reg_check(msi_pkg::REG_EN_HI);
		for (int i = 0; i < msi_pkg::NVEC; i++)
			reg_write(msi_pkg::REG_VT_BASE | 7'(i), rand_bits(17));
		for (int i = 0; i < msi_pkg::NVEC; i++)
			reg_check(msi_pkg::REG_VT_BASE | 7'(i));
		reg_check(msi_pkg::REG_STAT);

		// pending set and write-one clear with global enable off
		reg_write(msi_pkg::REG_CTRL, 32'h0);
		for (int i = 0; i < 20; i++) begin
			m = rand_msg(3'(rand_bits(3)));
			expect_msg(m);
			send_msg(m);
		end
		wait_drain();
		reg_check(msi_pkg::REG_PEND_LO);
		reg_check(msi_pkg::REG_PEND_HI);
		reg_write(msi_pkg::REG_PEND_LO, rand_bits(32));
		reg_write(msi_pkg::REG_PEND_HI, rand_bits(32));
		reg_check(msi_pkg::REG_PEND_LO);
		reg_check(msi_pkg::REG_PEND_HI);

		// delivery filter with config changed only while idle
		for (int b = 0; b < 6; b++) begin
			thr = {1'b0, 2'(rand_bits(2))};
			reg_write(msi_pkg::REG_CTRL, {28'b0, thr, rand_bits(2) != 32'h0});
			reg_write(msi_pkg::REG_EN_LO, rand_bits(32) | rand_bits(32));
			reg_write(msi_pkg::REG_EN_HI, rand_bits(32) | rand_bits(32));
			for (int i = 0; i < 8; i++)
				reg_write(msi_pkg::REG_VT_BASE | 7'(rand_bits(6)), rand_bits(17));
			for (int i = 0; i < 20; i++) begin
				m = rand_msg(3'(rand_bits(3)));
				expect_msg(m);
				send_msg(m);
				wait_drain();
			end
		end

		// everything enabled for ordering and back-pressure
		reg_write(msi_pkg::REG_CTRL, 32'h1);
		reg_write(msi_pkg::REG_EN_LO, 32'hffff_ffff);
		reg_write(msi_pkg::REG_EN_HI, 32'hffff_ffff);
		for (int i = 0; i < msi_pkg::NVEC; i++)
			reg_write(msi_pkg::REG_VT_BASE | 7'(i), 32'h1_0000 | rand_bits(16));
		repeat (3) priority_round();
		repeat (2) backpressure_round();

		wait_drain();
		reg_check(msi_pkg::REG_PEND_LO);
		reg_check(msi_pkg::REG_PEND_HI);
		repeat (20) @(negedge clk);
		if (exp_q.size() == 0 && got_q.size() == 0 && !irq_o) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("expected interrupts were still outstanding at the end of the run");
			$display("TEST RESULT: FAIL");
			$fatal(1, "outstanding deliveries");
		end
	end

endmodule

//--- tb.f
+incdir+testbench
src/msi_pkg.sv
src/msi_vec_table.sv
src/msi_queue.sv
src/msi_intake.sv
src/msi_dispatch.sv
src/msi_regs.sv
src/msi_ctrl.sv
testbench/tb_msi_ctrl.sv

//--- Makefile
SIM    := verilator
FLAGS  := --binary --timing --assert -j 0
TOP    := tb_msi_ctrl
FLIST  := tb.f
OBJDIR := obj_dir

SRCS := $(filter-out +%,$(shell cat $(FLIST))) testbench/tb_msi_ref.svh
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
